//--- common/dcachePkg.sv
package dcachePkg;

  // address and word geometry
  localparam int AddrWidth = 32;
  localparam int WordWidth = 64;
  localparam int LineWords = 4;
  localparam int NumSets = 64;

  // byte address split: tag | index | offset
  localparam int OffsetBits = 5;
  localparam int IndexBits = 6;
  localparam int TagBits = AddrWidth - IndexBits - OffsetBits;

  localparam int LineBytes = LineWords * WordWidth / 8;
  localparam int LineBits = LineWords * WordWidth;

  // one cache line
  // store merging works on bytes, refill and load on words
  typedef union packed {
    logic [LineWords-1:0][WordWidth-1:0] words;
    logic [LineBytes-1:0][7:0] bytes;
  } lineT;

endpackage

//--- common/lookupIf.sv
`timescale 1ns/1ps

interface lookupIf #(
  parameter int NumWays = 2
);

  localparam int WayBits = (NumWays > 1) ? $clog2(NumWays) : 1;

  // lookup result for the latched index and tag
  logic hit;
  logic [WayBits-1:0] hitWay;
  logic [WayBits-1:0] victimWay;
  logic victimDirty;

  // array updates requested by the FSM
  logic storeWrite;
  logic install;

  modport tags (output hit, hitWay, victimWay, victimDirty, input storeWrite, install);

  modport fsm (input hit, victimDirty, output storeWrite, install);

  modport data (input hitWay, victimWay, storeWrite, install);

endinterface

//--- source/dcacheFsm.sv
`timescale 1ns/1ps

module dcacheFsm (
  input  logic clk,
  input  logic rst_n,
  input  logic reqValid_i,
  input  logic reqWrite_i,
  input  logic memRdReady_i,
  input  logic memWrReady_i,
  input  logic memRdLast_i,
  input  logic memDataValid_i,
  lookupIf.fsm lk,
  output logic reqReady_o,
  output logic accept_o,
  output logic rspValid_o,
  output logic memRdValid_o,
  output logic memWrValid_o
);

  localparam logic [2:0] Idle = 3'd0;
  localparam logic [2:0] Lookup = 3'd1;
  localparam logic [2:0] WriteBack = 3'd2;
  localparam logic [2:0] ReadReq = 3'd3;
  localparam logic [2:0] Refill = 3'd4;
  localparam logic [2:0] Install = 3'd5;

  logic [2:0] stateQ;
  logic [2:0] stateD;

  assign reqReady_o = (stateQ == Idle);
  assign accept_o = reqReady_o && reqValid_i;
  assign rspValid_o = (stateQ == Lookup) && lk.hit;
  // store hit merges its bytes in the same cycle as the response
  assign lk.storeWrite = rspValid_o && reqWrite_i;
  assign memWrValid_o = (stateQ == WriteBack);
  assign memRdValid_o = (stateQ == ReadReq);
  assign lk.install = (stateQ == Install);

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      Idle: if (accept_o) stateD = Lookup;
      Lookup: begin
        if (lk.hit) stateD = Idle;
        else if (lk.victimDirty) stateD = WriteBack;
        else stateD = ReadReq;
      end
      WriteBack: if (memWrReady_i) stateD = ReadReq;
      ReadReq: if (memRdReady_i) stateD = Refill;
      Refill: if (memDataValid_i && memRdLast_i) stateD = Install;
      // look the request up again, it hits on the new line
      Install: stateD = Lookup;
      default: stateD = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= Idle;
    end else begin
      stateQ <= stateD;
    end
  end

endmodule

//--- source/requestLatch.sv
`timescale 1ns/1ps

module requestLatch (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    accept_i,
  input  logic                                    reqWrite_i,
  input  logic [dcachePkg::AddrWidth-1:0]         reqAddr_i,
  input  logic [dcachePkg::WordWidth-1:0]         wrData_i,
  input  logic [7:0]                              wrMask_i,
  output logic                                    isWrite_o,
  output logic [dcachePkg::IndexBits-1:0]         index_o,
  output logic [dcachePkg::TagBits-1:0]           tag_o,
  output logic [$clog2(dcachePkg::LineWords)-1:0] wordSel_o,
  output dcachePkg::lineT                         storeLine_o,
  output logic [dcachePkg::LineBytes-1:0]         storeEnable_o
);

  localparam int ByteBits = $clog2(dcachePkg::WordWidth / 8);
  localparam int SelBits = $clog2(dcachePkg::LineWords);

  logic [dcachePkg::AddrWidth-1:0] addrQ;
  logic [SelBits-1:0] wordD;
  dcachePkg::lineT storeLineD;
  logic [dcachePkg::LineBytes-1:0] storeEnableD;

  assign wordD = reqAddr_i[ByteBits +: SelBits];

  // shift data and mask to the byte lane, then into the addressed word
  always_comb begin
    storeLineD = '0;
    storeEnableD = '0;
    storeLineD.words[wordD] = wrData_i << {reqAddr_i[ByteBits-1:0], 3'b000};
    storeEnableD[wordD*8 +: 8] = wrMask_i << reqAddr_i[ByteBits-1:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      isWrite_o <= 1'b0;
      addrQ <= '0;
    end else if (accept_i) begin
      isWrite_o <= reqWrite_i;
      addrQ <= reqAddr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept_i) begin
      storeLine_o <= storeLineD;
      storeEnable_o <= storeEnableD;
    end
  end

  assign index_o = addrQ[dcachePkg::OffsetBits +: dcachePkg::IndexBits];
  assign tag_o = addrQ[dcachePkg::AddrWidth-1 -: dcachePkg::TagBits];
  assign wordSel_o = addrQ[ByteBits +: SelBits];

endmodule

//--- source/refillBuffer.sv
`timescale 1ns/1ps

module refillBuffer (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            memDataValid_i,
  input  logic [dcachePkg::WordWidth-1:0] memData_i,
  input  logic                            clear_i,
  output dcachePkg::lineT                 line_o
);

  logic [$clog2(dcachePkg::LineWords)-1:0] countQ;

  // beat counter, wraps after the last word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      countQ <= '0;
    end else if (clear_i) begin
      countQ <= '0;
    end else if (memDataValid_i) begin
      countQ <= countQ + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (memDataValid_i) begin
      line_o.words[countQ] <= memData_i;
    end
  end

endmodule

//--- storage/tagStore.sv
`timescale 1ns/1ps

module tagStore #(
  parameter int NumWays = 2
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [dcachePkg::IndexBits-1:0] index_i,
  input  logic [dcachePkg::TagBits-1:0]   tag_i,
  lookupIf.tags                           lk,
  output logic [dcachePkg::AddrWidth-1:0] wbAddr_o
);

  localparam int WayBits = (NumWays > 1) ? $clog2(NumWays) : 1;

  logic [dcachePkg::TagBits-1:0] tagQ [NumWays][dcachePkg::NumSets];
  logic [NumWays-1:0][dcachePkg::NumSets-1:0] validQ;
  logic [NumWays-1:0][dcachePkg::NumSets-1:0] dirtyQ;
  // way to replace next in each set
  logic [dcachePkg::NumSets-1:0][WayBits-1:0] lruQ;

  logic freeAny;
  logic [WayBits-1:0] freeWay;
  logic [WayBits-1:0] victimWay;

  // with two ways this is true LRU, with more it turns into round robin
  function automatic logic [WayBits-1:0] nextWay(input logic [WayBits-1:0] way);
    return (way == WayBits'(NumWays - 1)) ? '0 : way + 1'b1;
  endfunction

  // downward scan so the lowest way wins
  always_comb begin
    lk.hit = 1'b0;
    lk.hitWay = '0;
    freeAny = 1'b0;
    freeWay = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (validQ[w][index_i] && (tagQ[w][index_i] == tag_i)) begin
        lk.hit = 1'b1;
        lk.hitWay = WayBits'(w);
      end
      if (!validQ[w][index_i]) begin
        freeAny = 1'b1;
        freeWay = WayBits'(w);
      end
    end
  end

  assign victimWay = freeAny ? freeWay : lruQ[index_i];
  assign lk.victimWay = victimWay;
  assign lk.victimDirty = validQ[victimWay][index_i] && dirtyQ[victimWay][index_i];
  assign wbAddr_o = {tagQ[victimWay][index_i], index_i, {dcachePkg::OffsetBits{1'b0}}};

  // a hit seen again while idle marks the same way, which changes nothing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      dirtyQ <= '0;
      lruQ <= '0;
    end else if (lk.install) begin
      validQ[victimWay][index_i] <= 1'b1;
      dirtyQ[victimWay][index_i] <= 1'b0;
      lruQ[index_i] <= nextWay(victimWay);
    end else if (lk.hit) begin
      lruQ[index_i] <= nextWay(lk.hitWay);
      if (lk.storeWrite) dirtyQ[lk.hitWay][index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (lk.install) tagQ[victimWay][index_i] <= tag_i;
  end

endmodule

//--- storage/dataArray.sv
`timescale 1ns/1ps

module dataArray #(
  parameter int NumWays = 2
) (
  input  logic                                    clk,
  input  logic [dcachePkg::IndexBits-1:0]         index_i,
  input  logic [$clog2(dcachePkg::LineWords)-1:0] wordSel_i,
  input  dcachePkg::lineT                         storeLine_i,
  input  logic [dcachePkg::LineBytes-1:0]         storeEnable_i,
  input  dcachePkg::lineT                         refillLine_i,
  lookupIf.data                                   lk,
  output logic [dcachePkg::WordWidth-1:0]         rdData_o,
  output dcachePkg::lineT                         victimLine_o
);

  dcachePkg::lineT lineQ [NumWays][dcachePkg::NumSets];
  dcachePkg::lineT hitLine;

  // install replaces the whole victim line, a store touches only enabled bytes
  always_ff @(posedge clk) begin
    if (lk.install) begin
      lineQ[lk.victimWay][index_i] <= refillLine_i;
    end else if (lk.storeWrite) begin
      for (int b = 0; b < dcachePkg::LineBytes; b++) begin
        if (storeEnable_i[b]) begin
          lineQ[lk.hitWay][index_i].bytes[b] <= storeLine_i.bytes[b];
        end
      end
    end
  end

  assign hitLine = lineQ[lk.hitWay][index_i];
  assign rdData_o = hitLine.words[wordSel_i];

  // whole line goes out for write-back
  assign victimLine_o = lineQ[lk.victimWay][index_i];

endmodule

//--- source/dcacheTop.sv
`timescale 1ns/1ps

module dcacheTop #(
  parameter int NumWays = 2
) (
  input  logic                            clk,
  input  logic                            rst_n,
  // pipeline side
  input  logic                            reqValid_i,
  input  logic                            reqWrite_i,
  input  logic [dcachePkg::AddrWidth-1:0] reqAddr_i,
  input  logic [dcachePkg::WordWidth-1:0] wrData_i,
  input  logic [7:0]                      wrMask_i,
  output logic                            reqReady_o,
  output logic                            rspValid_o,
  output logic [dcachePkg::WordWidth-1:0] rdData_o,
  // memory read side
  output logic                            memRdValid_o,
  output logic [dcachePkg::AddrWidth-1:0] memRdAddr_o,
  input  logic                            memRdReady_i,
  input  logic [dcachePkg::WordWidth-1:0] memData_i,
  input  logic                            memDataValid_i,
  input  logic                            memRdLast_i,
  // memory write side
  output logic                            memWrValid_o,
  output logic [dcachePkg::AddrWidth-1:0] memWrAddr_o,
  output logic [dcachePkg::LineBits-1:0]  memWrData_o,
  input  logic                            memWrReady_i
);

  logic accept;
  logic isWrite;
  logic [dcachePkg::IndexBits-1:0] index;
  logic [dcachePkg::TagBits-1:0] tag;
  logic [$clog2(dcachePkg::LineWords)-1:0] wordSel;
  dcachePkg::lineT storeLine;
  logic [dcachePkg::LineBytes-1:0] storeEnable;
  dcachePkg::lineT refillLine;

  lookupIf #(.NumWays(NumWays)) lk ();

  // refill always fetches the whole line of the latched request
  assign memRdAddr_o = {tag, index, {dcachePkg::OffsetBits{1'b0}}};

  dcacheFsm i_fsm (
    .clk, .rst_n, .reqValid_i, .reqWrite_i(isWrite),
    .memRdReady_i, .memWrReady_i, .memRdLast_i, .memDataValid_i,
    .lk(lk.fsm), .reqReady_o, .accept_o(accept), .rspValid_o, .memRdValid_o, .memWrValid_o
  );

  requestLatch i_reqLatch (
    .clk, .rst_n, .accept_i(accept), .reqWrite_i, .reqAddr_i, .wrData_i, .wrMask_i,
    .isWrite_o(isWrite), .index_o(index), .tag_o(tag), .wordSel_o(wordSel),
    .storeLine_o(storeLine), .storeEnable_o(storeEnable)
  );

  refillBuffer i_refill (
    .clk, .rst_n, .memDataValid_i, .memData_i, .clear_i(lk.install), .line_o(refillLine)
  );

  tagStore #(.NumWays(NumWays)) i_tags (
    .clk, .rst_n, .index_i(index), .tag_i(tag), .lk(lk.tags), .wbAddr_o(memWrAddr_o)
  );

  dataArray #(.NumWays(NumWays)) i_data (
    .clk, .index_i(index), .wordSel_i(wordSel), .storeLine_i(storeLine),
    .storeEnable_i(storeEnable), .refillLine_i(refillLine), .lk(lk.data),
    .rdData_o, .victimLine_o(memWrData_o)
  );

endmodule

//--- bench/memModel.sv
`timescale 1ns/1ps

module memModel #(
  parameter logic [31:0] Seed = 32'h1
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         memRdValid_i,
  input  logic [31:0]  memRdAddr_i,
  output logic         memRdReady_o,
  output logic [63:0]  memData_o,
  output logic         memDataValid_o,
  output logic         memRdLast_o,
  input  logic         memWrValid_i,
  input  logic [31:0]  memWrAddr_i,
  input  logic [255:0] memWrData_i,
  output logic         memWrReady_o
);

  // written words by byte address
  logic [63:0] store [logic [31:0]];
  logic [31:0] rng;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // untouched words read as the complement of their address
  function automatic logic [63:0] readWord(input logic [31:0] a);
    if (store.exists(a)) return store[a];
    return ~{32'h0, a};
  endfunction

  initial begin
    rng = Seed;
    memRdReady_o = 1'b0;
    memData_o = '0;
    memDataValid_o = 1'b0;
    memRdLast_o = 1'b0;
    memWrReady_o = 1'b0;
    forever begin
      @(negedge clk);
      rng = xorshift32(rng);
      if (rst_n && memWrValid_i) begin
        repeat (rng[1:0]) @(negedge clk);
        for (int w = 0; w < 4; w++) begin
          store[memWrAddr_i + 32'(8 * w)] = memWrData_i[64*w +: 64];
        end
        memWrReady_o = 1'b1;
        @(negedge clk);
        memWrReady_o = 1'b0;
      end else if (rst_n && memRdValid_i) begin
        repeat (rng[1:0]) @(negedge clk);
        memRdReady_o = 1'b1;
        @(negedge clk);
        memRdReady_o = 1'b0;
        // four beats in address order
        for (int w = 0; w < 4; w++) begin
          memDataValid_o = 1'b1;
          memRdLast_o = (w == 3);
          memData_o = readWord(memRdAddr_i + 32'(8 * w));
          @(negedge clk);
        end
        memDataValid_o = 1'b0;
        memRdLast_o = 1'b0;
      end
    end
  end

endmodule

//--- bench/dcacheTb.sv
`timescale 1ns/1ps

module dcacheTb;

  localparam int NumRequests = 16;
  localparam int CycleLimit = 40 * NumRequests;

  logic clk = 1'b0;
  logic rst_n;
  logic reqValid;
  logic reqWrite;
  logic [31:0] reqAddr;
  logic [63:0] wrData;
  logic [7:0] wrMask;
  logic reqReady;
  logic rspValid;
  logic [63:0] rdData;
  logic memRdValid;
  logic [31:0] memRdAddr;
  logic memRdReady;
  logic [63:0] memData;
  logic memDataValid;
  logic memRdLast;
  logic memWrValid;
  logic [31:0] memWrAddr;
  logic [255:0] memWrData;
  logic memWrReady;

  // expected results of the request in flight
  logic idleCheck;
  logic expectMiss;
  logic expectEvict;
  logic [63:0] expWord;
  logic [31:0] expWbAddr;
  logic [255:0] expWbLine;
  logic sawRead;
  logic sawWrite;
  // reference bytes from own stores
  // unwritten bytes follow the memory fill rule
  logic [7:0] refMem [logic [31:0]];
  logic [31:0] rng = 32'h495f;
  int errors = 0;
  int testStart = 0;
  int cycles = 0;

  dcacheTop #(.NumWays(2)) i_dut (
    .clk, .rst_n, .reqValid_i(reqValid), .reqWrite_i(reqWrite), .reqAddr_i(reqAddr),
    .wrData_i(wrData), .wrMask_i(wrMask), .reqReady_o(reqReady), .rspValid_o(rspValid),
    .rdData_o(rdData), .memRdValid_o(memRdValid), .memRdAddr_o(memRdAddr),
    .memRdReady_i(memRdReady), .memData_i(memData), .memDataValid_i(memDataValid),
    .memRdLast_i(memRdLast), .memWrValid_o(memWrValid), .memWrAddr_o(memWrAddr),
    .memWrData_o(memWrData), .memWrReady_i(memWrReady)
  );

  memModel #(.Seed(32'h495f)) memory (
    .clk, .rst_n, .memRdValid_i(memRdValid), .memRdAddr_i(memRdAddr),
    .memRdReady_o(memRdReady), .memData_o(memData), .memDataValid_o(memDataValid),
    .memRdLast_o(memRdLast), .memWrValid_i(memWrValid), .memWrAddr_i(memWrAddr),
    .memWrData_i(memWrData), .memWrReady_o(memWrReady)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [7:0] refByte(input logic [31:0] a);
    logic [63:0] fill;
    fill = ~{32'h0, a[31:3], 3'b000};
    if (refMem.exists(a)) return refMem[a];
    return fill[a[2:0]*8 +: 8];
  endfunction

  function automatic logic [63:0] refWord(input logic [31:0] a);
    logic [63:0] w;
    for (int b = 0; b < 8; b++) w[b*8 +: 8] = refByte({a[31:3], 3'(b)});
    return w;
  endfunction

  function automatic logic [255:0] refLine(input logic [31:0] a);
    logic [255:0] line;
    for (int w = 0; w < 4; w++) line[64*w +: 64] = refWord({a[31:5], 2'(w), 3'b000});
    return line;
  endfunction

  function automatic logic [31:0] lineAddr(input logic [20:0] tag, input logic [5:0] set,
                                           input logic [1:0] word);
    return {tag, set, word, 3'b000};
  endfunction

  function automatic void reportMismatch(input string name, input logic [255:0] got,
                                         input logic [255:0] exp);
    $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
    errors++;
  endfunction

  // memory traffic seen since the last acceptance
  always @(posedge clk) begin
    if (reqValid && reqReady) begin
      sawRead <= 1'b0;
      sawWrite <= 1'b0;
    end else begin
      if (memRdValid) sawRead <= 1'b1;
      if (memWrValid) sawWrite <= 1'b1;
    end
  end

  assert property (@(posedge clk) idleCheck |-> reqReady && !rspValid && !memRdValid
                   && !memWrValid)
    else begin
      $display("cache is not idle and ready after reset at %0t", $time);
      errors++;
    end
  assert property (@(posedge clk) reqValid && reqReady && !expectMiss |=> rspValid)
    else reportMismatch("rspValid_o", $sampled(rspValid), 1);
  assert property (@(posedge clk) rspValid && !reqWrite |-> rdData == expWord)
    else reportMismatch("rdData_o", $sampled(rdData), expWord);
  assert property (@(posedge clk) rspValid |-> sawRead == expectMiss)
    else reportMismatch("memRdValid_o", $sampled(sawRead), expectMiss);
  assert property (@(posedge clk) rspValid |-> sawWrite == expectEvict)
    else reportMismatch("memWrValid_o", $sampled(sawWrite), expectEvict);
  assert property (@(posedge clk) memRdValid |-> memRdAddr == {reqAddr[31:5], 5'b0})
    else reportMismatch("memRdAddr_o", $sampled(memRdAddr), {reqAddr[31:5], 5'b0});
  assert property (@(posedge clk) memWrValid |-> memWrAddr == expWbAddr)
    else reportMismatch("memWrAddr_o", $sampled(memWrAddr), expWbAddr);
  assert property (@(posedge clk) memWrValid |-> memWrData == expWbLine)
    else reportMismatch("memWrData_o", $sampled(memWrData), expWbLine);

  always @(posedge clk) begin
    cycles++;
    if (cycles > CycleLimit) begin
      $display("run stopped, no result after %0d cycles", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // drives one request from a falling edge and waits for its response
  task automatic access(input logic write, input logic [31:0] addr, input logic miss,
                        input logic evict, input logic [31:0] victim);
    while (!reqReady) @(negedge clk);
    rng = xorshift32(rng);
    wrData[63:32] = rng;
    rng = xorshift32(rng);
    wrData[31:0] = rng;
    wrMask = rng[7:0];
    reqValid = 1'b1;
    reqWrite = write;
    reqAddr = addr;
    expectMiss = miss;
    expectEvict = evict;
    expWord = refWord(addr);
    expWbAddr = {victim[31:5], 5'b0};
    expWbLine = refLine(victim);
    if (write) begin
      for (int b = 0; b < 8; b++) begin
        if (wrMask[b]) refMem[addr + 32'(b)] = wrData[b*8 +: 8];
      end
    end
    @(negedge clk);
    reqValid = 1'b0;
    while (!rspValid) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic report(input int num, input string name);
    $display("test %0d %s: %s", num, name, (errors == testStart) ? "ok" : "mismatch");
    testStart = errors;
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [20:0] t;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr = '0;
    wrData = '0;
    wrMask = '0;
    idleCheck = 1'b0;
    expectMiss = 1'b0;
    expectEvict = 1'b0;
    expWord = '0;
    expWbAddr = '0;
    expWbLine = '0;
    sawRead = 1'b0;
    sawWrite = 1'b0;
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    idleCheck = 1'b1;
    repeat (2) @(negedge clk);
    idleCheck = 1'b0;
    report(1, "idle after reset");

    // tests 2 to 4 on one line of set 1
    rng = xorshift32(rng);
    a = lineAddr(rng[20:0], 6'd1, rng[22:21]);
    access(1'b0, a, 1'b1, 1'b0, '0);
    report(2, "first load misses");
    access(1'b0, a, 1'b0, 1'b0, '0);
    report(3, "repeated load hits");
    b = {a[31:5], a[4:3] + 2'd1, 3'b000};
    access(1'b0, b, 1'b0, 1'b0, '0);
    access(1'b1, b, 1'b0, 1'b0, '0);
    access(1'b0, b, 1'b0, 1'b0, '0);
    report(4, "store hit merges bytes");

    // dirty first line in set 2 is the LRU victim of the third
    rng = xorshift32(rng);
    t = rng[20:0];
    a = lineAddr(t, 6'd2, rng[22:21]);
    access(1'b0, a, 1'b1, 1'b0, '0);
    access(1'b1, a, 1'b0, 1'b0, '0);
    access(1'b0, lineAddr(t ^ 21'd1, 6'd2, 2'd0), 1'b1, 1'b0, '0);
    access(1'b0, lineAddr(t ^ 21'd2, 6'd2, 2'd1), 1'b1, 1'b1, a);
    access(1'b0, lineAddr(t ^ 21'd3, 6'd2, 2'd2), 1'b1, 1'b0, '0);
    report(5, "dirty eviction writes back");

    // access order A B A C A B in set 3
    rng = xorshift32(rng);
    t = rng[20:0];
    a = lineAddr(t, 6'd3, rng[22:21]);
    b = lineAddr(t ^ 21'd1, 6'd3, rng[24:23]);
    access(1'b0, a, 1'b1, 1'b0, '0);
    access(1'b0, b, 1'b1, 1'b0, '0);
    access(1'b0, a, 1'b0, 1'b0, '0);
    access(1'b0, lineAddr(t ^ 21'd2, 6'd3, 2'd3), 1'b1, 1'b0, '0);
    access(1'b0, a, 1'b0, 1'b0, '0);
    access(1'b0, b, 1'b1, 1'b0, '0);
    report(6, "least recently used replaced");

    $display("%0d tests done, %0d checks failed", 6, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
common/dcachePkg.sv
common/lookupIf.sv
source/dcacheFsm.sv
source/requestLatch.sv
source/refillBuffer.sv
storage/tagStore.sv
storage/dataArray.sv
source/dcacheTop.sv
bench/memModel.sv
bench/dcacheTb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - common/dcachePkg.sv
      - common/lookupIf.sv
      - source/dcacheFsm.sv
      - source/requestLatch.sv
      - source/refillBuffer.sv
      - storage/tagStore.sv
      - storage/dataArray.sv
      - source/dcacheTop.sv
  - target: test
    files:
      - bench/memModel.sv
      - bench/dcacheTb.sv
